/* design/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_SB      = 6'h28,
        OP_SW      = 6'h2b
    } opcode_t;

    // function field of SPECIAL
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_fmt_t;

    // one fetched word, read through either field layout
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        word_t  raw;
    } inst_t;

    localparam word_t NOP_WORD = 32'h0000_0000; // sll r0,r0,0

endpackage

`default_nettype wire

/* design/mips_pipe_pkg.sv */
`default_nettype none

package mips_pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

    typedef enum logic [0:0] {
        SIZE_BYTE,
        SIZE_WORD
    } mem_size_t;

    typedef struct packed {
        mips_isa_pkg::word_t addr;
        logic                read;
    } ibus_req_t;

    typedef struct packed {
        mips_isa_pkg::word_t addr;
        logic [3:0]          byte_en;
        logic                read;
        logic                write;
        mips_isa_pkg::word_t wr_data;
    } dbus_req_t;

    typedef struct packed {
        alu_op_t                 alu_op;
        mips_isa_pkg::word_t     operand_a;
        mips_isa_pkg::word_t     operand_b;
        mips_isa_pkg::word_t     store_val;
        mips_isa_pkg::reg_addr_t dest;
        mem_op_t                 mem_op;
        mem_size_t               mem_size;
        logic                    mem_unsigned;
        logic                    reg_we;
    } id_ex_t;

    typedef struct packed {
        mips_isa_pkg::word_t     result; // alu result or effective address
        mips_isa_pkg::word_t     store_val;
        mips_isa_pkg::reg_addr_t dest;
        mem_op_t                 mem_op;
        mem_size_t               mem_size;
        logic                    mem_unsigned;
        logic                    reg_we;
    } ex_mm_t;

    typedef struct packed {
        mips_isa_pkg::reg_addr_t dest;
        mips_isa_pkg::word_t     value;
        logic                    reg_we;
    } wb_t;

    typedef struct packed {
        logic en_pc;
        logic en_ifid;
        logic en_idex;
        logic en_exmm;
        logic en_mmwb;
    } stage_en_t;

endpackage

`default_nettype wire

/* design/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
    parameter mips_isa_pkg::word_t RESET_PC = 32'h0
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        en_i,
    input  wire                        branch_taken_i,
    input  wire mips_isa_pkg::word_t   branch_target_i,
    input  wire                        ibus_stall_i,
    output mips_pipe_pkg::ibus_req_t   ibus_o,
    output mips_isa_pkg::word_t        pc_o
);

    mips_isa_pkg::word_t pc_q;
    mips_isa_pkg::word_t hold_addr_q;
    logic                hold_q;
    logic                started_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (en_i) begin
            pc_q <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
        end
    end

    // read stays low until the first clock after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started_q <= 1'b0;
            hold_q    <= 1'b0;
        end else begin
            started_q <= 1'b1;
            hold_q    <= ibus_o.read & ibus_stall_i; // read still pending
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_q && ibus_o.read) begin
            hold_addr_q <= pc_q; // first cycle of a read
        end
    end

    assign ibus_o.addr = hold_q ? hold_addr_q : pc_q;
    assign ibus_o.read = started_q | hold_q;
    assign pc_o        = pc_q;

endmodule

`default_nettype wire

/* design/decode_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_unit (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire mips_pipe_pkg::stage_en_t  stage_en_i,
    input  wire mips_isa_pkg::word_t       pc_i,
    input  wire mips_isa_pkg::word_t       ibus_rddata_i,
    input  wire mips_pipe_pkg::wb_t        ex_fwd_i,
    input  wire mips_pipe_pkg::wb_t        mm_fwd_i,
    input  wire mips_pipe_pkg::wb_t        wb_i,
    output mips_pipe_pkg::id_ex_t          id_ex_o,
    output mips_isa_pkg::reg_addr_t        src_s_o,
    output mips_isa_pkg::reg_addr_t        src_t_o,
    output logic                           branch_taken_o,
    output mips_isa_pkg::word_t            branch_target_o
);

    mips_isa_pkg::inst_t inst_q;
    mips_isa_pkg::word_t pc_q;
    mips_isa_pkg::word_t regs [32];
    mips_isa_pkg::word_t rs_val;
    mips_isa_pkg::word_t rt_val;
    mips_isa_pkg::word_t imm_se;
    mips_isa_pkg::word_t slot_pc;
    logic                dest_we;

    always_ff @(posedge clk) begin
        if (!rst_n || (!stage_en_i.en_ifid && stage_en_i.en_idex)) begin
            inst_q <= mips_isa_pkg::NOP_WORD; // bubble
        end else if (stage_en_i.en_ifid) begin
            inst_q <= ibus_rddata_i;
            pc_q   <= pc_i;
        end
    end

    // r0 is never written, dest 0 has reg_we cleared
    always_ff @(posedge clk) begin
        if (wb_i.reg_we) begin
            regs[wb_i.dest] <= wb_i.value;
        end
    end

    function automatic mips_isa_pkg::word_t fwd_val(mips_isa_pkg::reg_addr_t addr);
        mips_isa_pkg::word_t val;
        val = (addr == 5'd0) ? 32'h0 : regs[addr];
        if (wb_i.reg_we && wb_i.dest == addr) val = wb_i.value;
        if (mm_fwd_i.reg_we && mm_fwd_i.dest == addr) val = mm_fwd_i.value;
        if (ex_fwd_i.reg_we && ex_fwd_i.dest == addr) val = ex_fwd_i.value; // newest wins
        return val;
    endfunction

    always_comb begin
        rs_val = fwd_val(inst_q.r.rs);
        rt_val = fwd_val(inst_q.r.rt);
    end

    assign src_s_o = inst_q.r.rs;
    assign src_t_o = inst_q.r.rt;
    assign imm_se  = {{16{inst_q.i.imm16[15]}}, inst_q.i.imm16};
    assign slot_pc = pc_q + 32'd4;

    always_comb begin
        id_ex_o.alu_op       = mips_pipe_pkg::ALU_ADD;
        id_ex_o.operand_a    = rs_val;
        id_ex_o.operand_b    = imm_se;
        id_ex_o.store_val    = rt_val;
        id_ex_o.dest         = inst_q.i.rt;
        id_ex_o.mem_op       = mips_pipe_pkg::MEM_NONE;
        id_ex_o.mem_size     = mips_pipe_pkg::SIZE_WORD;
        id_ex_o.mem_unsigned = 1'b0;
        dest_we              = 1'b1;
        case (inst_q.r.opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                id_ex_o.operand_b = rt_val;
                id_ex_o.dest      = inst_q.r.rd;
                case (inst_q.r.funct)
                    mips_isa_pkg::FN_ADDU: id_ex_o.alu_op = mips_pipe_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: id_ex_o.alu_op = mips_pipe_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  id_ex_o.alu_op = mips_pipe_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   id_ex_o.alu_op = mips_pipe_pkg::ALU_OR;
                    mips_isa_pkg::FN_SLT:  id_ex_o.alu_op = mips_pipe_pkg::ALU_SLT;
                    default:               dest_we = 1'b0;
                endcase
            end
            mips_isa_pkg::OP_ADDIU: ;
            mips_isa_pkg::OP_ORI: begin
                id_ex_o.alu_op    = mips_pipe_pkg::ALU_OR;
                id_ex_o.operand_b = {16'h0, inst_q.i.imm16};
            end
            mips_isa_pkg::OP_LUI: id_ex_o.alu_op = mips_pipe_pkg::ALU_LUI;
            mips_isa_pkg::OP_LW:  id_ex_o.mem_op = mips_pipe_pkg::MEM_LOAD;
            mips_isa_pkg::OP_LB, mips_isa_pkg::OP_LBU: begin
                id_ex_o.mem_op       = mips_pipe_pkg::MEM_LOAD;
                id_ex_o.mem_size     = mips_pipe_pkg::SIZE_BYTE;
                id_ex_o.mem_unsigned = inst_q.r.opcode == mips_isa_pkg::OP_LBU;
            end
            mips_isa_pkg::OP_SW, mips_isa_pkg::OP_SB: begin
                id_ex_o.mem_op = mips_pipe_pkg::MEM_STORE;
                if (inst_q.r.opcode == mips_isa_pkg::OP_SB) id_ex_o.mem_size = mips_pipe_pkg::SIZE_BYTE;
                dest_we = 1'b0;
            end
            default: dest_we = 1'b0; // branches and unknown opcodes
        endcase
        id_ex_o.reg_we = dest_we && (id_ex_o.dest != 5'd0);
    end

    // branches compare forwarded values, target is relative to the delay slot
    always_comb begin
        branch_target_o = slot_pc + {imm_se[29:0], 2'b00};
        case (inst_q.r.opcode)
            mips_isa_pkg::OP_BEQ: branch_taken_o = rs_val == rt_val;
            mips_isa_pkg::OP_BNE: branch_taken_o = rs_val != rt_val;
            mips_isa_pkg::OP_J: begin
                branch_taken_o  = 1'b1;
                branch_target_o = {slot_pc[31:28], inst_q.raw[25:0], 2'b00};
            end
            default: branch_taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* design/execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire mips_pipe_pkg::stage_en_t  stage_en_i,
    input  wire mips_pipe_pkg::id_ex_t     id_ex_i,
    output mips_pipe_pkg::ex_mm_t          ex_mm_o,
    output mips_pipe_pkg::wb_t             ex_fwd_o,
    output logic                           ex_is_load_o
);

    mips_pipe_pkg::id_ex_t id_ex_q;
    mips_isa_pkg::word_t   alu_res;

    always_ff @(posedge clk) begin
        if (!rst_n || (!stage_en_i.en_idex && stage_en_i.en_exmm)) begin
            id_ex_q.reg_we <= 1'b0; // bubble
            id_ex_q.mem_op <= mips_pipe_pkg::MEM_NONE;
        end else if (stage_en_i.en_idex) begin
            id_ex_q <= id_ex_i;
        end
    end

    always_comb begin
        case (id_ex_q.alu_op)
            mips_pipe_pkg::ALU_SUB: alu_res = id_ex_q.operand_a - id_ex_q.operand_b;
            mips_pipe_pkg::ALU_AND: alu_res = id_ex_q.operand_a & id_ex_q.operand_b;
            mips_pipe_pkg::ALU_OR:  alu_res = id_ex_q.operand_a | id_ex_q.operand_b;
            mips_pipe_pkg::ALU_SLT: begin
                alu_res = {31'h0, $signed(id_ex_q.operand_a) < $signed(id_ex_q.operand_b)};
            end
            mips_pipe_pkg::ALU_LUI: alu_res = {id_ex_q.operand_b[15:0], 16'h0};
            default:                alu_res = id_ex_q.operand_a + id_ex_q.operand_b;
        endcase
    end

    always_comb begin
        ex_mm_o.result       = alu_res; // effective address for loads and stores
        ex_mm_o.store_val    = id_ex_q.store_val;
        ex_mm_o.dest         = id_ex_q.dest;
        ex_mm_o.mem_op       = id_ex_q.mem_op;
        ex_mm_o.mem_size     = id_ex_q.mem_size;
        ex_mm_o.mem_unsigned = id_ex_q.mem_unsigned;
        ex_mm_o.reg_we       = id_ex_q.reg_we;
    end

    // load data is not known yet in EX
    assign ex_is_load_o    = id_ex_q.mem_op == mips_pipe_pkg::MEM_LOAD;
    assign ex_fwd_o.dest   = id_ex_q.dest;
    assign ex_fwd_o.value  = alu_res;
    assign ex_fwd_o.reg_we = id_ex_q.reg_we && !ex_is_load_o;

endmodule

`default_nettype wire

/* design/memory_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module memory_unit (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire mips_pipe_pkg::stage_en_t  stage_en_i,
    input  wire mips_pipe_pkg::ex_mm_t     ex_mm_i,
    output mips_pipe_pkg::dbus_req_t       dbus_o,
    input  wire mips_isa_pkg::word_t       dbus_rddata_i,
    output mips_pipe_pkg::wb_t             mm_fwd_o,
    output logic                           mm_is_load_o,
    output mips_pipe_pkg::wb_t             wb_o
);

    mips_pipe_pkg::ex_mm_t ex_mm_q;
    mips_pipe_pkg::wb_t    wb_q;
    mips_isa_pkg::word_t   lane;
    mips_isa_pkg::word_t   load_val;
    logic                  is_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mm_q.reg_we <= 1'b0;
            ex_mm_q.mem_op <= mips_pipe_pkg::MEM_NONE;
        end else if (stage_en_i.en_exmm) begin
            ex_mm_q <= ex_mm_i;
        end
    end

    assign is_word      = ex_mm_q.mem_size == mips_pipe_pkg::SIZE_WORD;
    assign mm_is_load_o = ex_mm_q.mem_op == mips_pipe_pkg::MEM_LOAD;

    always_comb begin
        dbus_o.addr  = ex_mm_q.result;
        dbus_o.read  = mm_is_load_o;
        dbus_o.write = ex_mm_q.mem_op == mips_pipe_pkg::MEM_STORE;
        if (ex_mm_q.mem_op == mips_pipe_pkg::MEM_NONE) dbus_o.byte_en = 4'b0000;
        else if (is_word) dbus_o.byte_en = 4'b1111;
        else dbus_o.byte_en = 4'b0001 << ex_mm_q.result[1:0];
        dbus_o.wr_data = is_word ? ex_mm_q.store_val : {4{ex_mm_q.store_val[7:0]}}; // byte on all lanes
    end

    // bus data is only valid in the cycle the access is accepted
    always_comb begin
        lane = dbus_rddata_i >> {ex_mm_q.result[1:0], 3'b000};
        if (is_word) load_val = dbus_rddata_i;
        else if (ex_mm_q.mem_unsigned) load_val = {24'h0, lane[7:0]};
        else load_val = {{24{lane[7]}}, lane[7:0]};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_q.reg_we <= 1'b0;
        end else if (stage_en_i.en_mmwb) begin
            wb_q.reg_we <= ex_mm_q.reg_we;
            wb_q.dest   <= ex_mm_q.dest;
            wb_q.value  <= mm_is_load_o ? load_val : ex_mm_q.result;
        end
    end

    assign mm_fwd_o.dest   = ex_mm_q.dest;
    assign mm_fwd_o.value  = ex_mm_q.result;
    assign mm_fwd_o.reg_we = ex_mm_q.reg_we && !mm_is_load_o;
    assign wb_o            = wb_q;

endmodule

`default_nettype wire

/* design/hazard_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard_ctrl (
    input  wire                           ibus_stall_i,
    input  wire                           dbus_stall_i,
    input  wire                           ex_is_load_i,
    input  wire mips_isa_pkg::reg_addr_t  ex_dest_i,
    input  wire                           mm_is_load_i,
    input  wire mips_isa_pkg::reg_addr_t  mm_dest_i,
    input  wire mips_isa_pkg::reg_addr_t  src_s_i,
    input  wire mips_isa_pkg::reg_addr_t  src_t_i,
    output mips_pipe_pkg::stage_en_t      stage_en_o
);

    logic ex_hit;
    logic mm_hit;

    assign ex_hit = ex_is_load_i && ex_dest_i != 5'd0
                    && (ex_dest_i == src_s_i || ex_dest_i == src_t_i);
    assign mm_hit = mm_is_load_i && mm_dest_i != 5'd0
                    && (mm_dest_i == src_s_i || mm_dest_i == src_t_i);

    always_comb begin
        stage_en_o = '{default: 1'b1};
        if (dbus_stall_i) begin
            stage_en_o = '{default: 1'b0}; // freeze everything
        end else if (ex_hit || mm_hit || ibus_stall_i) begin
            stage_en_o.en_pc   = 1'b0; // drain EX and MM, bubble into ID/EX
            stage_en_o.en_ifid = 1'b0;
            stage_en_o.en_idex = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/naive_core.sv */
`timescale 1ns/10ps
`default_nettype none

module naive_core #(
    parameter mips_isa_pkg::word_t RESET_PC = 32'h0
) (
    input  wire                        clk,
    input  wire                        rst_n,
    output mips_pipe_pkg::ibus_req_t   ibus_o,
    input  wire mips_isa_pkg::word_t   ibus_rddata_i,
    input  wire                        ibus_stall_i,
    output mips_pipe_pkg::dbus_req_t   dbus_o,
    input  wire mips_isa_pkg::word_t   dbus_rddata_i,
    input  wire                        dbus_stall_i
);

    mips_pipe_pkg::stage_en_t stage_en;
    mips_pipe_pkg::id_ex_t    id_ex;
    mips_pipe_pkg::ex_mm_t    ex_mm;
    mips_pipe_pkg::wb_t       ex_fwd;
    mips_pipe_pkg::wb_t       mm_fwd;
    mips_pipe_pkg::wb_t       wb;
    mips_isa_pkg::word_t      if_pc;
    mips_isa_pkg::word_t      branch_target;
    mips_isa_pkg::reg_addr_t  src_s;
    mips_isa_pkg::reg_addr_t  src_t;
    logic                     branch_taken;
    logic                     ex_is_load;
    logic                     mm_is_load;

    fetch_unit #(.RESET_PC(RESET_PC)) fetch_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .en_i            (stage_en.en_pc),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .ibus_stall_i    (ibus_stall_i),
        .ibus_o          (ibus_o),
        .pc_o            (if_pc)
    );

    decode_unit decode_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .stage_en_i      (stage_en),
        .pc_i            (if_pc),
        .ibus_rddata_i   (ibus_rddata_i),
        .ex_fwd_i        (ex_fwd),
        .mm_fwd_i        (mm_fwd),
        .wb_i            (wb),
        .id_ex_o         (id_ex),
        .src_s_o         (src_s),
        .src_t_o         (src_t),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    execute_unit execute_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .stage_en_i   (stage_en),
        .id_ex_i      (id_ex),
        .ex_mm_o      (ex_mm),
        .ex_fwd_o     (ex_fwd),
        .ex_is_load_o (ex_is_load)
    );

    memory_unit memory_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .stage_en_i    (stage_en),
        .ex_mm_i       (ex_mm),
        .dbus_o        (dbus_o),
        .dbus_rddata_i (dbus_rddata_i),
        .mm_fwd_o      (mm_fwd),
        .mm_is_load_o  (mm_is_load),
        .wb_o          (wb)
    );

    hazard_ctrl hazard_i (
        .ibus_stall_i (ibus_stall_i),
        .dbus_stall_i (dbus_stall_i),
        .ex_is_load_i (ex_is_load),
        .ex_dest_i    (ex_fwd.dest),
        .mm_is_load_i (mm_is_load),
        .mm_dest_i    (mm_fwd.dest),
        .src_s_i      (src_s),
        .src_t_i      (src_t),
        .stage_en_o   (stage_en)
    );

endmodule

`default_nettype wire

/* tb/bus_model.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_model (
    input  wire                            clk,
    input  wire mips_pipe_pkg::ibus_req_t  ibus_i,
    output logic                           ibus_stall_o,
    output mips_isa_pkg::word_t            ibus_rddata_o,
    input  wire mips_pipe_pkg::dbus_req_t  dbus_i,
    output logic                           dbus_stall_o,
    output mips_isa_pkg::word_t            dbus_rddata_o,
    output mips_pipe_pkg::ibus_req_t       fetch_o,  // read accepted at the next rising edge
    output mips_pipe_pkg::dbus_req_t       store_o   // write accepted at the next rising edge
);

    mips_isa_pkg::word_t rom [64]; // loaded by the testbench
    mips_isa_pkg::word_t ram [64];
    integer              seed;
    logic                i_stall;
    logic                d_stall;
    int                  k;
    int                  b;

    initial begin
        seed          = 32'h634ffb50;
        ibus_stall_o  = 1'b0;
        dbus_stall_o  = 1'b0;
        ibus_rddata_o = 32'h0;
        dbus_rddata_o = 32'h0;
        fetch_o       = '0;
        store_o       = '0;
        for (k = 0; k < 64; k++) begin
            ram[k] = 32'hdead_0000 | (k * 32'h0000_0101);
        end
    end

    // requests are stable from the rising edge, so the whole cycle is decided here
    always @(negedge clk) begin
        i_stall = ($random(seed) & 3) == 0; // about one cycle in four
        d_stall = ($random(seed) & 3) == 0;
        ibus_stall_o  = i_stall;
        dbus_stall_o  = d_stall;
        // read data only in the cycle the read is accepted
        ibus_rddata_o = (ibus_i.read && !i_stall) ? rom[ibus_i.addr[7:2]] : 32'h0;
        dbus_rddata_o = (dbus_i.read && !d_stall) ? ram[dbus_i.addr[7:2]] : 32'h0;
        fetch_o = '0;
        store_o = '0;
        if (ibus_i.read && !i_stall) begin
            fetch_o = ibus_i;
        end
        if (dbus_i.write && !d_stall) begin
            store_o = dbus_i;
            for (b = 0; b < 4; b++) begin
                if (dbus_i.byte_en[b]) begin
                    ram[dbus_i.addr[7:2]][8*b +: 8] = dbus_i.wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_core;

    localparam int PROG_LEN     = 39;
    localparam int N_STORES     = 13;
    localparam int CLK_PERIOD   = 100;
    localparam int DRAIN_CYCLES = 40;
    localparam int WATCHDOG_NS  = 40 * PROG_LEN * CLK_PERIOD;

    // MIPS32 encodings
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LB    = 6'h20;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_LBU   = 6'h24;
    localparam logic [5:0] OP_SB    = 6'h28;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    typedef struct packed {
        mips_isa_pkg::word_t addr;
        logic [3:0]          be;
        mips_isa_pkg::word_t data;
    } store_t;

    logic                     clk;
    logic                     rst_n;
    mips_pipe_pkg::ibus_req_t ibus;
    mips_isa_pkg::word_t      ibus_rddata;
    logic                     ibus_stall;
    mips_pipe_pkg::dbus_req_t dbus;
    mips_isa_pkg::word_t      dbus_rddata;
    logic                     dbus_stall;
    mips_pipe_pkg::ibus_req_t fetch;
    mips_pipe_pkg::dbus_req_t store;
    mips_isa_pkg::word_t      prog [PROG_LEN];
    store_t                   expected [N_STORES];
    int                       value_errors;
    int                       other_errors;
    int                       store_count;
    logic                     fetch_seen;
    int                       i;

    function automatic mips_isa_pkg::word_t rr_inst(input logic [5:0] funct,
            input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'h00, funct};
    endfunction

    function automatic mips_isa_pkg::word_t imm_inst(input logic [5:0] op,
            input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_isa_pkg::word_t jump_inst(input logic [25:0] word_index);
        return {OP_J, word_index};
    endfunction

    naive_core #(.RESET_PC(32'h0)) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ibus_o        (ibus),
        .ibus_rddata_i (ibus_rddata),
        .ibus_stall_i  (ibus_stall),
        .dbus_o        (dbus),
        .dbus_rddata_i (dbus_rddata),
        .dbus_stall_i  (dbus_stall)
    );

    bus_model bus_i (
        .clk           (clk),
        .ibus_i        (ibus),
        .ibus_stall_o  (ibus_stall),
        .ibus_rddata_o (ibus_rddata),
        .dbus_i        (dbus),
        .dbus_stall_o  (dbus_stall),
        .dbus_rddata_o (dbus_rddata),
        .fetch_o       (fetch),
        .store_o       (store)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: only %0d of %0d expected stores arrived", store_count, N_STORES);
        $display("RESULT: FAIL");
        $finish;
    end

    always @(posedge clk) begin
        if (store.write) store_count = store_count + 1;
        if (fetch.read && !fetch_seen) begin
            fetch_seen = 1'b1;
            if (fetch.addr != 32'h0) begin
                value_errors++;
                $display("error at %0t: first fetch at %h, expected 0", $time, fetch.addr);
            end
        end
    end

    task automatic check_store(input int idx);
        if (store.addr != expected[idx].addr) begin
            value_errors++;
            $display("error at %0t: store %0d address %h, expected %h",
                     $time, idx, store.addr, expected[idx].addr);
        end
        if (store.byte_en != expected[idx].be) begin
            value_errors++;
            $display("error at %0t: store %0d byte_en %b, expected %b",
                     $time, idx, store.byte_en, expected[idx].be);
        end
        if (store.wr_data != expected[idx].data) begin
            value_errors++;
            $display("error at %0t: store %0d data %h, expected %h",
                     $time, idx, store.wr_data, expected[idx].data);
        end
    endtask

    task automatic check_dbus_idle(input string phase);
        if (dbus.read !== 1'b0 || dbus.write !== 1'b0 || dbus.byte_en !== 4'b0000) begin
            value_errors++;
            $display("error at %0t: data bus not idle %s", $time, phase);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        value_errors = 0;
        other_errors = 0;
        store_count  = 0;
        fetch_seen   = 1'b0;

        prog[0]  = imm_inst(OP_ADDIU, 5'd1, 5'd0, 16'h0005);  // r1 = 5
        prog[1]  = imm_inst(OP_ORI, 5'd2, 5'd0, 16'h8001);    // zero extended
        prog[2]  = imm_inst(OP_LUI, 5'd3, 5'd0, 16'h1234);
        prog[3]  = rr_inst(FN_ADDU, 5'd4, 5'd3, 5'd2);        // EX and MM forward
        prog[4]  = rr_inst(FN_SUBU, 5'd5, 5'd4, 5'd1);
        prog[5]  = rr_inst(FN_AND, 5'd6, 5'd5, 5'd4);
        prog[6]  = rr_inst(FN_OR, 5'd7, 5'd6, 5'd1);
        prog[7]  = rr_inst(FN_SLT, 5'd8, 5'd1, 5'd7);
        prog[8]  = imm_inst(OP_SW, 5'd4, 5'd0, 16'h0000);
        prog[9]  = imm_inst(OP_SW, 5'd5, 5'd0, 16'h0004);
        prog[10] = imm_inst(OP_SW, 5'd6, 5'd0, 16'h0008);
        prog[11] = imm_inst(OP_SW, 5'd7, 5'd0, 16'h000c);
        prog[12] = imm_inst(OP_SW, 5'd8, 5'd0, 16'h0010);
        prog[13] = imm_inst(OP_ADDIU, 5'd9, 5'd0, 16'hfffd); // r9 = -3
        prog[14] = rr_inst(FN_SLT, 5'd10, 5'd9, 5'd8);       // signed compare
        prog[15] = imm_inst(OP_SW, 5'd10, 5'd0, 16'h0014);
        prog[16] = imm_inst(OP_LW, 5'd11, 5'd0, 16'h0000);
        prog[17] = rr_inst(FN_ADDU, 5'd12, 5'd11, 5'd1);     // load-use
        prog[18] = imm_inst(OP_SW, 5'd12, 5'd0, 16'h0018);
        prog[19] = imm_inst(OP_ORI, 5'd13, 5'd0, 16'h12c5);
        prog[20] = imm_inst(OP_SB, 5'd13, 5'd0, 16'h0021);
        prog[21] = imm_inst(OP_LB, 5'd14, 5'd0, 16'h0021);
        prog[22] = imm_inst(OP_LBU, 5'd15, 5'd0, 16'h0021);
        prog[23] = imm_inst(OP_SW, 5'd14, 5'd0, 16'h0028);
        prog[24] = imm_inst(OP_SW, 5'd15, 5'd0, 16'h002c);
        prog[25] = imm_inst(OP_BEQ, 5'd1, 5'd1, 16'h0002);   // taken, to word 28
        prog[26] = imm_inst(OP_ADDIU, 5'd16, 5'd0, 16'h0011); // delay slot
        prog[27] = imm_inst(OP_SW, 5'd1, 5'd0, 16'h0030);    // skipped
        prog[28] = imm_inst(OP_SW, 5'd16, 5'd0, 16'h0034);
        prog[29] = imm_inst(OP_BNE, 5'd1, 5'd1, 16'h0003);   // not taken
        prog[30] = imm_inst(OP_ADDIU, 5'd17, 5'd0, 16'h0022);
        prog[31] = imm_inst(OP_ADDIU, 5'd17, 5'd17, 16'h0100);
        prog[32] = imm_inst(OP_SW, 5'd17, 5'd0, 16'h0038);
        prog[33] = jump_inst(26'd36);
        prog[34] = imm_inst(OP_ADDIU, 5'd18, 5'd0, 16'h0033); // delay slot
        prog[35] = imm_inst(OP_SW, 5'd1, 5'd0, 16'h003c);    // skipped
        prog[36] = imm_inst(OP_SW, 5'd18, 5'd0, 16'h0040);
        prog[37] = jump_inst(26'd37);                        // park here
        prog[38] = 32'h0000_0000;

        expected[0]  = '{32'h0000_0000, 4'b1111, 32'h1234_8001};
        expected[1]  = '{32'h0000_0004, 4'b1111, 32'h1234_7ffc};
        expected[2]  = '{32'h0000_0008, 4'b1111, 32'h1234_0000};
        expected[3]  = '{32'h0000_000c, 4'b1111, 32'h1234_0005};
        expected[4]  = '{32'h0000_0010, 4'b1111, 32'h0000_0001};
        expected[5]  = '{32'h0000_0014, 4'b1111, 32'h0000_0001};
        expected[6]  = '{32'h0000_0018, 4'b1111, 32'h1234_8006};
        expected[7]  = '{32'h0000_0021, 4'b0010, 32'hc5c5_c5c5};
        expected[8]  = '{32'h0000_0028, 4'b1111, 32'hffff_ffc5};
        expected[9]  = '{32'h0000_002c, 4'b1111, 32'h0000_00c5};
        expected[10] = '{32'h0000_0034, 4'b1111, 32'h0000_0011};
        expected[11] = '{32'h0000_0038, 4'b1111, 32'h0000_0122};
        expected[12] = '{32'h0000_0040, 4'b1111, 32'h0000_0033};

        for (i = 0; i < 64; i++) begin
            if (i < PROG_LEN) bus_i.rom[i] = prog[i];
            else bus_i.rom[i] = 32'h0000_0000;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_dbus_idle("during reset");
        if (ibus.read !== 1'b0) begin
            value_errors++;
            $display("error at %0t: instruction read high during reset", $time);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_dbus_idle("after reset");
        if (ibus.read !== 1'b1 || ibus.addr !== 32'h0) begin
            value_errors++;
            $display("error at %0t: no instruction read at 0 after reset", $time);
        end

        for (i = 0; i < N_STORES; i++) begin
            @(posedge clk);
            while (!store.write) @(posedge clk);
            check_store(i);
        end

        // the core parks in a jump loop, any later store is spurious
        repeat (DRAIN_CYCLES) @(posedge clk);
        @(negedge clk);
        if (store_count != N_STORES) begin
            other_errors++;
            $display("the core made %0d stores but only %0d were expected",
                     store_count, N_STORES);
        end

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
design/mips_isa_pkg.sv
design/mips_pipe_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/memory_unit.sv
design/hazard_ctrl.sv
design/naive_core.sv
tb/bus_model.sv
tb/tb_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_core -Mdir obj_dir -o tb_core_sim -f project.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "no result line found in sim.log"
    exit 1
fi
exit 0
